// ==== verilog/exu_settings.svh ====
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

`define XLEN 32
`define NUM_REGS 32

// machine csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

`define ECALL_CAUSE 11 // environment call from m-mode

`endif

// ==== verilog/exu_pkg.sv ====
`include "exu_settings.svh"

package exu_pkg;

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and,
    alu_and_not, // csrrc
    alu_pass_b,
    alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_e;

  typedef enum logic [1:0] {op2_rs2, op2_imm, op2_csr} operand2_sel_e;

  typedef enum logic [2:0] {
    npc_seq,
    npc_pc_imm,
    npc_alu,    // jalr, bit 0 cleared
    npc_branch,
    npc_csr     // ecall and mret
  } npc_sel_e;

  typedef enum logic [1:0] {wd_alu, wd_seq, wd_pc_imm, wd_csr} wdata_sel_e;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    logic [`XLEN-1:0] csr_src;
    alu_op_e          alu_op;
    operand2_sel_e    operand2_sel;
    npc_sel_e         npc_sel;
    wdata_sel_e       wdata_sel;
    logic [4:0]       rd;
    logic             rd_we;
    logic [11:0]      csr_addr;
    logic             csr_we;
    logic             is_ecall;
    logic             illegal;
  } decoded_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] npc;
    logic [4:0]       rd;
    logic             rd_we;
    logic [`XLEN-1:0] rd_wdata;
    logic [11:0]      csr_addr;
    logic             csr_we;
    logic [`XLEN-1:0] csr_wdata;
    logic             illegal;
  } commit_t;

endpackage

// ==== verilog/alu.sv ====
`timescale 1ns/10ps
`include "exu_settings.svh"

module alu
  import exu_pkg::*;
(
  input  alu_op_e          op,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic [`XLEN-1:0] result
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign eq = a == b;
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    result = '0;
    case (op)
      alu_add:     result = a + b;
      alu_sub:     result = a - b;
      alu_sll:     result = a << shamt;
      alu_slt:     result[0] = lt_s;
      alu_sltu:    result[0] = lt_u;
      alu_xor:     result = a ^ b;
      alu_srl:     result = a >> shamt;
      alu_sra:     result = $unsigned($signed(a) >>> shamt);
      alu_or:      result = a | b;
      alu_and:     result = a & b;
      alu_and_not: result = a & ~b;
      alu_pass_b:  result = b;
      // branch compares, taken flag in bit 0
      alu_eq:      result[0] = eq;
      alu_ne:      result[0] = !eq;
      alu_lt:      result[0] = lt_s;
      alu_ge:      result[0] = !lt_s;
      alu_ltu:     result[0] = lt_u;
      alu_geu:     result[0] = !lt_u;
      default:     result = '0;
    endcase
  end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/10ps
`include "exu_settings.svh"

module regfile (
  input  logic             clock,
  input  logic             reset,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  output logic [`XLEN-1:0] rdata1,
  output logic [`XLEN-1:0] rdata2,
  input  logic             we,
  input  logic [4:0]       rd,
  input  logic [`XLEN-1:0] wdata
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin // x0 stays zero
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

  a_x0_zero: assert property (@(posedge clock) disable iff (reset)
    (rs1 == 5'd0 |-> rdata1 == '0) and (rs2 == 5'd0 |-> rdata2 == '0));

endmodule

// ==== verilog/csr_file.sv ====
`timescale 1ns/10ps
`include "exu_settings.svh"

module csr_file (
  input  logic             clock,
  input  logic             reset,
  input  logic [11:0]      addr,
  output logic [`XLEN-1:0] rdata,
  output logic             known,
  input  logic             we,
  input  logic [`XLEN-1:0] wdata,
  input  logic             ecall,
  input  logic [`XLEN-1:0] ecall_pc
);

  logic [`XLEN-1:0] mstatus;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;
  logic [`XLEN-1:0] mcause;

  always_comb begin
    known = 1'b1;
    rdata = '0;
    case (addr)
      `CSR_MSTATUS: rdata = mstatus;
      `CSR_MTVEC:   rdata = mtvec;
      `CSR_MEPC:    rdata = mepc;
      `CSR_MCAUSE:  rdata = mcause;
      default:      known = 1'b0; // reads zero
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= '0;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
    end else begin
      if (we) begin
        case (addr)
          `CSR_MSTATUS: mstatus <= wdata;
          `CSR_MTVEC:   mtvec <= wdata;
          `CSR_MEPC:    mepc <= wdata;
          `CSR_MCAUSE:  mcause <= wdata;
          default:      ;
        endcase
      end
      if (ecall) begin // trap entry
        mepc <= ecall_pc;
        mcause <= `ECALL_CAUSE;
      end
    end
  end

endmodule

// ==== verilog/idu.sv ====
`timescale 1ns/10ps
`include "exu_settings.svh"

module idu
  import exu_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             inst_valid,
  output logic             inst_ready,
  input  logic [31:0]      inst,
  input  logic [`XLEN-1:0] pc,
  output logic [4:0]       rs1,
  output logic [4:0]       rs2,
  input  logic [`XLEN-1:0] rdata1,
  input  logic [`XLEN-1:0] rdata2,
  output logic [11:0]      csr_addr,
  input  logic [`XLEN-1:0] csr_rdata,
  input  logic             csr_known,
  output logic             dvalid,
  input  logic             dready,
  output decoded_t         decoded,
  input  logic             busy_clear
);

  logic             busy;
  logic             take;
  decoded_t         dec;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [4:0]       rd;
  logic [11:0]      sys_addr;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = alt ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  endfunction

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // ecall reads mtvec, mret reads mepc
  assign sys_addr = (funct3 != 3'b000) ? inst[31:20]
                  : (inst[31:20] == 12'h302) ? `CSR_MEPC : `CSR_MTVEC;
  // held address serves the csr write on the commit cycle
  assign csr_addr = busy ? decoded.csr_addr : sys_addr;

  always_comb begin
    dec = '0;
    dec.pc = pc;
    dec.imm = imm_i;
    dec.src1 = rdata1;
    dec.src2 = rdata2;
    dec.csr_src = csr_rdata;
    dec.alu_op = alu_add;
    dec.operand2_sel = op2_rs2;
    dec.npc_sel = npc_seq;
    dec.wdata_sel = wd_alu;
    dec.rd = rd;
    case (opcode)
      opc_lui: begin
        dec.imm = imm_u;
        dec.alu_op = alu_pass_b;
        dec.operand2_sel = op2_imm;
        dec.rd_we = 1'b1;
      end
      opc_auipc: begin
        dec.imm = imm_u;
        dec.wdata_sel = wd_pc_imm;
        dec.rd_we = 1'b1;
      end
      opc_jal: begin
        dec.imm = imm_j;
        dec.npc_sel = npc_pc_imm;
        dec.wdata_sel = wd_seq;
        dec.rd_we = 1'b1;
      end
      opc_jalr: begin
        dec.operand2_sel = op2_imm;
        dec.npc_sel = npc_alu;
        dec.wdata_sel = wd_seq;
        dec.rd_we = 1'b1;
        dec.illegal = funct3 != 3'b000;
      end
      opc_branch: begin
        dec.imm = imm_b;
        dec.npc_sel = npc_branch;
        case (funct3)
          3'b000:  dec.alu_op = alu_eq;
          3'b001:  dec.alu_op = alu_ne;
          3'b100:  dec.alu_op = alu_lt;
          3'b101:  dec.alu_op = alu_ge;
          3'b110:  dec.alu_op = alu_ltu;
          3'b111:  dec.alu_op = alu_geu;
          default: dec.illegal = 1'b1;
        endcase
      end
      opc_op_imm: begin
        dec.alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
        dec.operand2_sel = op2_imm;
        dec.rd_we = 1'b1;
        if (funct3 == 3'b001 && funct7 != 7'b0)
          dec.illegal = 1'b1;
        if (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0)
          dec.illegal = 1'b1;
      end
      opc_op: begin
        dec.alu_op = arith_op(funct3, funct7[5]);
        dec.rd_we = 1'b1;
        if ((funct7 & 7'b1011111) != 7'b0)
          dec.illegal = 1'b1;
        if (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101)
          dec.illegal = 1'b1;
      end
      opc_system: begin
        dec.csr_addr = sys_addr;
        dec.wdata_sel = wd_csr; // old csr value to rd
        dec.rd_we = 1'b1;
        dec.csr_we = 1'b1;
        case (funct3)
          3'b001: begin // csrrw, rs1 value goes out on b
            dec.alu_op = alu_pass_b;
            dec.src2 = rdata1;
          end
          3'b010: begin
            dec.alu_op = alu_or;
            dec.operand2_sel = op2_csr;
            dec.csr_we = rs1 != 5'd0;
          end
          3'b011: begin // csr & ~rs1
            dec.alu_op = alu_and_not;
            dec.src1 = csr_rdata;
            dec.src2 = rdata1;
            dec.csr_we = rs1 != 5'd0;
          end
          3'b000: begin // ecall or mret
            dec.rd_we = 1'b0;
            dec.csr_we = 1'b0;
            dec.npc_sel = npc_csr;
            dec.is_ecall = inst[31:20] == 12'h000;
            if (inst[19:7] != 13'b0 || (inst[31:20] != 12'h000 && inst[31:20] != 12'h302))
              dec.illegal = 1'b1;
          end
          default: dec.illegal = 1'b1;
        endcase
        if (funct3 != 3'b000 && !csr_known)
          dec.illegal = 1'b1;
      end
      default: dec.illegal = 1'b1;
    endcase
    if (dec.illegal) begin
      dec.rd_we = 1'b0;
      dec.csr_we = 1'b0;
      dec.is_ecall = 1'b0;
      dec.npc_sel = npc_seq;
    end else if (rd == 5'd0) begin
      dec.rd_we = 1'b0;
    end
  end

  assign take = inst_valid && inst_ready;
  assign inst_ready = !busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      dvalid <= 1'b0;
    end else if (take) begin
      busy <= 1'b1;
      dvalid <= 1'b1;
    end else begin
      if (busy_clear)
        busy <= 1'b0;
      if (dvalid && dready)
        dvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take)
      decoded <= dec; // operands sampled here
  end

  a_decoded_held: assert property (@(posedge clock) disable iff (reset)
    dvalid && !dready |=> $stable(decoded));

endmodule

// ==== verilog/exu.sv ====
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu
  import exu_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             dvalid,
  output logic             dready,
  input  decoded_t         decoded,
  output logic             evalid,
  output alu_op_e          alu_op,
  output logic [`XLEN-1:0] alu_a,
  output logic [`XLEN-1:0] alu_b,
  input  logic [`XLEN-1:0] alu_result,
  output logic [`XLEN-1:0] npc,
  output logic [`XLEN-1:0] rd_wdata,
  output logic [`XLEN-1:0] csr_wdata
);

  decoded_t         held;
  logic [`XLEN-1:0] snpc;
  logic [`XLEN-1:0] dnpc;

  always_ff @(posedge clock) begin
    if (reset) begin
      dready <= 1'b1;
      evalid <= 1'b0;
    end else if (dvalid && dready) begin
      dready <= 1'b0;
      evalid <= 1'b1;
    end else if (evalid) begin
      evalid <= 1'b0;
      dready <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (dvalid && dready)
      held <= decoded;
  end

  assign snpc = held.pc + `XLEN'd4;
  assign dnpc = held.pc + held.imm;

  assign alu_op = held.alu_op;
  assign alu_a = held.src1;

  always_comb begin
    case (held.operand2_sel)
      op2_rs2: alu_b = held.src2;
      op2_imm: alu_b = held.imm;
      op2_csr: alu_b = held.csr_src; // csrrs
      default: alu_b = '0;
    endcase
  end

  always_comb begin
    case (held.npc_sel)
      npc_seq:    npc = snpc;
      npc_pc_imm: npc = dnpc;
      npc_alu:    npc = {alu_result[`XLEN-1:1], 1'b0};
      npc_branch: npc = alu_result[0] ? dnpc : snpc;
      npc_csr:    npc = held.csr_src;
      default:    npc = snpc;
    endcase
  end

  always_comb begin
    case (held.wdata_sel)
      wd_alu:    rd_wdata = alu_result;
      wd_seq:    rd_wdata = snpc; // link
      wd_pc_imm: rd_wdata = dnpc; // auipc
      default:   rd_wdata = held.csr_src;
    endcase
  end

  assign csr_wdata = alu_result;

  a_evalid_pulse: assert property (@(posedge clock) disable iff (reset)
    evalid |=> !evalid);

endmodule

// ==== verilog/exec_top.sv ====
`timescale 1ns/10ps
`include "exu_settings.svh"

module exec_top
  import exu_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             inst_valid,
  output logic             inst_ready,
  input  logic [31:0]      inst,
  input  logic [`XLEN-1:0] pc,
  output logic             commit_valid,
  output commit_t          commit
);

  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;
  logic [11:0]      csr_addr;
  logic [`XLEN-1:0] csr_rdata;
  logic             csr_known;
  logic             dvalid;
  logic             dready;
  logic             evalid;
  decoded_t         decoded;
  alu_op_e          alu_op;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_result;
  logic [`XLEN-1:0] npc;
  logic [`XLEN-1:0] rd_wdata;
  logic [`XLEN-1:0] csr_wdata;

  idu u_idu (
    .clock, .reset, .inst_valid, .inst_ready, .inst, .pc,
    .rs1, .rs2, .rdata1, .rdata2,
    .csr_addr, .csr_rdata, .csr_known,
    .dvalid, .dready, .decoded,
    .busy_clear(evalid)
  );

  exu u_exu (
    .clock, .reset, .dvalid, .dready, .decoded, .evalid,
    .alu_op, .alu_a, .alu_b, .alu_result,
    .npc, .rd_wdata, .csr_wdata
  );

  alu u_alu (
    .op    (alu_op),
    .a     (alu_a),
    .b     (alu_b),
    .result(alu_result)
  );

  // idu keeps its decoded word until the next take, so it matches exu's copy
  regfile u_regfile (
    .clock, .reset, .rs1, .rs2, .rdata1, .rdata2,
    .we   (evalid && decoded.rd_we),
    .rd   (decoded.rd),
    .wdata(rd_wdata)
  );

  csr_file u_csr_file (
    .clock, .reset,
    .addr    (csr_addr),
    .rdata   (csr_rdata),
    .known   (csr_known),
    .we      (evalid && decoded.csr_we),
    .wdata   (csr_wdata),
    .ecall   (evalid && decoded.is_ecall),
    .ecall_pc(decoded.pc)
  );

  assign commit_valid = evalid;
  assign commit = '{
    pc:        decoded.pc,
    npc:       npc,
    rd:        decoded.rd,
    rd_we:     decoded.rd_we,
    rd_wdata:  rd_wdata,
    csr_addr:  decoded.csr_addr,
    csr_we:    decoded.csr_we,
    csr_wdata: csr_wdata,
    illegal:   decoded.illegal
  };

endmodule

// ==== bench/exec_checker.sv ====
`timescale 1ns/10ps
`include "exu_settings.svh"

module exec_checker
  import exu_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             inst_valid,
  input  logic             inst_ready,
  input  logic [31:0]      inst,
  input  logic [`XLEN-1:0] pc,
  input  logic             commit_valid,
  input  commit_t          commit,
  output logic [`XLEN-1:0] model_pc,
  output int               mismatches,
  output int               protocol_errors,
  output int               commits
);

  logic [`XLEN-1:0] xreg [`NUM_REGS];
  logic [`XLEN-1:0] mstatus;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;
  logic [`XLEN-1:0] mcause;
  commit_t          expected;
  logic             pending;
  logic             ready_due;
  logic             was_reset;
  int               age;

  function automatic logic csr_known(input logic [11:0] addr);
    return addr == `CSR_MSTATUS || addr == `CSR_MTVEC || addr == `CSR_MEPC
        || addr == `CSR_MCAUSE;
  endfunction

  function automatic logic [`XLEN-1:0] csr_value(input logic [11:0] addr);
    case (addr)
      `CSR_MSTATUS: return mstatus;
      `CSR_MTVEC:   return mtvec;
      `CSR_MEPC:    return mepc;
      default:      return mcause;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return {31'b0, $signed(x) < $signed(y)};
      3'b011:  return {31'b0, x < y};
      3'b100:  return x ^ y;
      3'b101: begin
        if (alt)
          return $signed(x) >>> y[4:0];
        return x >> y[4:0];
      end
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // architectural result of one RV32I word against the mirrored state
  function automatic commit_t expect_commit(input logic [31:0] w, input logic [`XLEN-1:0] ipc);
    commit_t          e;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] res;
    logic             wr;
    logic             ill;
    f3 = w[14:12];
    f7 = w[31:25];
    a = xreg[w[19:15]];
    b = xreg[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    e = '0;
    e.pc = ipc;
    e.npc = ipc + 4;
    e.rd = w[11:7];
    res = '0;
    wr = 1'b1;
    ill = 1'b0;
    case (w[6:0])
      7'h37: res = {w[31:12], 12'b0}; // lui
      7'h17: res = ipc + {w[31:12], 12'b0};
      7'h6f: begin
        res = ipc + 4;
        e.npc = ipc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'h67: begin
        res = ipc + 4;
        e.npc = (a + imm_i) & ~32'h1;
        ill = f3 != 3'b000;
      end
      7'h63: begin
        wr = 1'b0;
        ill = f3[2:1] == 2'b01;
        if (branch_taken(f3, a, b))
          e.npc = ipc + imm_b;
      end
      7'h13: begin
        res = alu_ref(f3, f3 == 3'b101 && f7[5], a, imm_i);
        ill = (f3 == 3'b001 && f7 != 0) || (f3 == 3'b101 && f7 != 0 && f7 != 7'h20);
      end
      7'h33: begin
        res = alu_ref(f3, f7[5], a, b);
        ill = f7 != 0 && !(f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      end
      7'h73: begin
        if (f3 == 3'b000) begin // ecall or mret
          wr = 1'b0;
          if (w[19:7] != 0 || (w[31:20] != 12'h000 && w[31:20] != 12'h302))
            ill = 1'b1;
          else
            e.npc = (w[31:20] == 12'h000) ? mtvec : mepc;
        end else if (f3[2] || !csr_known(w[31:20])) begin
          ill = 1'b1;
        end else begin
          res = csr_value(w[31:20]);
          e.csr_addr = w[31:20];
          e.csr_we = f3 == 3'b001 || w[19:15] != 0;
          case (f3)
            3'b001:  e.csr_wdata = a;
            3'b010:  e.csr_wdata = res | a;
            default: e.csr_wdata = res & ~a;
          endcase
        end
      end
      default: ill = 1'b1;
    endcase
    if (ill) begin
      e.illegal = 1'b1;
      e.npc = ipc + 4;
      e.csr_we = 1'b0;
    end else begin
      e.rd_we = wr && e.rd != 0;
      e.rd_wdata = res;
    end
    return e;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH time=%0t signal=commit.%s expected=%h actual=%h",
               $time, name, exp, act);
    end
  endtask

  task automatic protocol_error(input string what);
    protocol_errors++;
    $display("ERROR time=%0t %s", $time, what);
  endtask

  task automatic check_commit();
    commits++;
    compare_field("pc", expected.pc, commit.pc);
    compare_field("npc", expected.npc, commit.npc);
    compare_field("rd", expected.rd, commit.rd);
    compare_field("rd_we", expected.rd_we, commit.rd_we);
    compare_field("csr_we", expected.csr_we, commit.csr_we);
    compare_field("illegal", expected.illegal, commit.illegal);
    if (expected.rd_we)
      compare_field("rd_wdata", expected.rd_wdata, commit.rd_wdata);
    if (expected.csr_we) begin
      compare_field("csr_addr", expected.csr_addr, commit.csr_addr);
      compare_field("csr_wdata", expected.csr_wdata, commit.csr_wdata);
    end
  endtask

  task automatic retire_model(input logic [31:0] w, input logic [`XLEN-1:0] ipc);
    expected = expect_commit(w, ipc);
    if (expected.rd_we)
      xreg[expected.rd] = expected.rd_wdata;
    if (expected.csr_we) begin
      case (expected.csr_addr)
        `CSR_MSTATUS: mstatus = expected.csr_wdata;
        `CSR_MTVEC:   mtvec = expected.csr_wdata;
        `CSR_MEPC:    mepc = expected.csr_wdata;
        default:      mcause = expected.csr_wdata;
      endcase
    end
    if (!expected.illegal && w == 32'h0000_0073) begin // trap entry
      mepc = ipc;
      mcause = `ECALL_CAUSE;
    end
    model_pc = expected.npc;
  endtask

  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++)
        xreg[i] = '0;
      mstatus = '0;
      mtvec = '0;
      mepc = '0;
      mcause = '0;
      pending = 1'b0;
      ready_due = 1'b0;
      was_reset = 1'b1;
      age = 0;
      model_pc = 32'h0000_1000; // boot pc
      mismatches = 0;
      protocol_errors = 0;
      commits = 0;
    end else begin
      if (was_reset && (!inst_ready || commit_valid))
        protocol_error("inst_ready low or commit_valid high right after reset");
      was_reset = 1'b0;
      if (ready_due && !inst_ready)
        protocol_error("inst_ready did not return high the cycle after commit");
      ready_due = 1'b0;
      if (pending) begin
        age++;
        if (inst_ready)
          protocol_error("inst_ready high while an instruction is in flight");
        if (commit_valid) begin
          if (age != 2)
            protocol_error($sformatf("commit came %0d cycles after the take, not 2", age));
          check_commit();
          pending = 1'b0;
          ready_due = 1'b1;
        end else if (age >= 4) begin
          protocol_error("instruction still pending 4 cycles after its take");
          pending = 1'b0;
        end
      end else if (commit_valid) begin
        protocol_error("commit_valid high without a pending instruction");
      end
      if (inst_valid && inst_ready) begin
        retire_model(inst, pc);
        pending = 1'b1;
        age = 0;
      end
    end
  end

endmodule

// ==== bench/exec_tb.sv ====
`timescale 1ns/10ps
`include "exu_settings.svh"

module exec_tb
  import exu_pkg::*;
();

  localparam int NUM_INST = 400;
  localparam int WATCHDOG_CYCLES = NUM_INST * 5 + 20;

  logic             clock;
  logic             reset;
  logic             inst_valid;
  logic             inst_ready;
  logic [31:0]      inst;
  logic [`XLEN-1:0] pc;
  logic             commit_valid;
  commit_t          commit;
  logic [`XLEN-1:0] model_pc;
  int               mismatches;
  int               protocol_errors;
  int               commits;
  logic [15:0]      lfsr;

  exec_top dut (
    .clock, .reset, .inst_valid, .inst_ready, .inst, .pc, .commit_valid, .commit
  );

  exec_checker chk (
    .clock, .reset, .inst_valid, .inst_ready, .inst, .pc, .commit_valid, .commit,
    .model_pc, .mismatches, .protocol_errors, .commits
  );

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] make_inst();
    logic [3:0]  kind;
    logic [3:0]  flags;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [19:0] upper;
    logic [11:0] csr;
    logic [31:0] word;
    kind = rand_bits(4);
    flags = rand_bits(4);
    f3 = rand_bits(3);
    rd = rand_bits(3); // x0..x7 for frequent reuse
    rs1 = rand_bits(3);
    rs2 = rand_bits(3);
    imm = rand_bits(12);
    upper = rand_bits(20);
    word = rand_bits(32);
    case (flags[1:0])
      2'd0:    csr = `CSR_MSTATUS;
      2'd1:    csr = `CSR_MTVEC;
      2'd2:    csr = `CSR_MEPC;
      default: csr = `CSR_MCAUSE;
    endcase
    if (word[2:0] == 3'd0)
      csr = 12'h7c0; // not implemented
    case (kind)
      4'd0, 4'd1, 4'd2, 4'd3:
        return {(f3 == 3'b000 || f3 == 3'b101) && flags[2] ? 7'h20 : 7'h00,
                rs2, rs1, f3, rd, 7'h33};
      4'd4, 4'd5: begin
        if (f3 == 3'b001)
          imm[11:5] = 7'h00;
        if (f3 == 3'b101)
          imm[11:5] = flags[2] ? 7'h20 : 7'h00;
        return {imm, rs1, f3, rd, 7'h13};
      end
      4'd6:        return {upper, rd, flags[3] ? 7'h37 : 7'h17};
      4'd7:        return {upper, rd, 7'h6f};
      4'd8:        return {imm, rs1, 3'b000, rd, 7'h67};
      4'd9, 4'd10: return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h63};
      4'd11, 4'd12:
        return {csr, rs1, 1'b0, f3[1:0] == 2'd0 ? 2'd1 : f3[1:0], rd, 7'h73};
      4'd13:       return flags[3] ? 32'h3020_0073 : 32'h0000_0073; // mret, ecall
      4'd14:       return word; // mostly illegal
      default:     return {upper[6:0], rs2, rs1, f3, rd, 7'h33};
    endcase
  endfunction

  task automatic print_summary();
    $display("summary: %0d mismatches, %0d protocol errors, %0d of %0d instructions committed",
             mismatches, protocol_errors, commits, NUM_INST);
  endtask

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    pc = '0;
    lfsr = 16'd51465;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    for (int n = 0; n < NUM_INST; n++) begin
      if (rand_bits(1) == 1)
        @(posedge clock); // idle gap
      inst_valid <= 1'b1;
      inst <= make_inst();
      pc <= model_pc; // model's npc, not the DUT's
      do @(posedge clock); while (!inst_ready);
      inst_valid <= 1'b0;
      do @(posedge clock); while (!commit_valid);
    end
    repeat (2) @(posedge clock);
    if (commits != NUM_INST)
      $display("ERROR: only %0d of %0d instructions committed", commits, NUM_INST);
    print_summary();
    if (mismatches == 0 && protocol_errors == 0 && commits == NUM_INST) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("ERROR: watchdog expired after %0d cycles before all instructions committed",
             WATCHDOG_CYCLES);
    print_summary();
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/exu_pkg.sv
verilog/alu.sv
verilog/regfile.sv
verilog/csr_file.sv
verilog/idu.sv
verilog/exu.sv
verilog/exec_top.sv
bench/exec_checker.sv
bench/exec_tb.sv

// ==== Bender.yml ====
package:
  name: exec_slice

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exu_pkg.sv
      - verilog/alu.sv
      - verilog/regfile.sv
      - verilog/csr_file.sv
      - verilog/idu.sv
      - verilog/exu.sv
      - verilog/exec_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/exec_checker.sv
      - bench/exec_tb.sv
